// ==== tb.f ====
common/buzzer_pkg.sv
hw/buzzer_regs.sv
hw/buzzer_timer.sv
hw/buzzer_fsm.sv
hw/buzzer_wave.sv
hw/buzzer_top.sv
bench/buzzer_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns
TOP       = buzzer_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir
PASS_MSG  = TEST OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The simulation passes only when the pass line appears in its output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/buzzer_tb.sv ====
`default_nettype none

module buzzer_tb
  import buzzer_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ns;

  localparam int BURST_LEN   = 8;
  localparam int N_BURSTS    = 6;
  localparam int MAX_HALF    = 28;  // Longest half period in clocks
  localparam int WRITE_SLACK = 16;  // Register writes, settling and stop per test
  localparam int CYCLE_LIMIT = 8 * (4 * MAX_HALF + WRITE_SLACK)
                             + N_BURSTS * (BURST_LEN * MAX_HALF + WRITE_SLACK)
                             + 400;

  // Half period in clocks per frequency select from clk/16 down to clk/56
  localparam int HALF_CLOCKS [8] = '{8, 10, 12, 14, 16, 20, 24, 28};

  logic       clk;
  logic       rst_n;
  logic       wr;
  logic       addr;
  logic [3:0] wdata;
  logic       buzzer;
  logic       buzzer_n;
  logic       busy;

  // Reference model state updated once per rising edge
  buzz_cfg_t m_cfg;
  logic      m_active;  // Tone playing, busy high
  logic      m_phase;
  logic      m_fresh;   // The previous edge took a write
  int        m_edges;   // Edges since the last write edge
  logic      exp_on;
  logic      exp_buzzer;
  logic      exp_buzzer_n;
  logic      exp_busy;

  string test_name;
  int    cycle_count;
  int    seed;

  buzzer_top #(
    .BURST_LEN (BURST_LEN)
  ) UUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr       (wr),
    .addr     (addr),
    .wdata    (wdata),
    .buzzer   (buzzer),
    .buzzer_n (buzzer_n),
    .busy     (busy)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    int   e;
    int   hp;
    logic act;
    logic ph;
    if (!rst_n) begin
      m_cfg    <= '0;
      m_active <= 1'b0;
      m_phase  <= 1'b0;
      m_fresh  <= 1'b0;
      m_edges  <= 0;
    end else begin
      act = m_active;
      ph  = m_phase;
      e   = m_edges;
      if (m_fresh) begin
        // Edge W+1 starts the tone low, or leaves it silent
        act = m_cfg.freq.enable && m_cfg.ctrl.pin_en;
        ph  = 1'b0;
        e   = 1;
      end else if (m_active) begin
        hp = HALF_CLOCKS[m_cfg.freq.sel];
        e  = m_edges + 1;
        if (e % hp == 0) begin  // Toggle at W+H, W+2H and so on
          ph = !ph;
          if (!m_cfg.ctrl.continuous && (e / hp == BURST_LEN)) begin
            act = 1'b0;
            ph  = 1'b0;
          end
        end
      end
      m_active <= act;
      m_phase  <= ph;
      m_edges  <= e;
      m_fresh  <= wr;
      if (wr) begin
        if (addr == ADDR_FREQ) begin
          m_cfg.freq <= freq_reg_t'(wdata);
        end else begin
          m_cfg.ctrl <= ctrl_reg_t'(wdata);
        end
      end
    end
  end

  // Written config gates the pins at once
  assign exp_on       = m_active && m_cfg.freq.enable && m_cfg.ctrl.pin_en;
  assign exp_buzzer   = exp_on && m_phase;
  assign exp_buzzer_n = exp_on && m_cfg.ctrl.comp_en && !m_phase;
  assign exp_busy     = m_active;

  task automatic report_mismatch(input string signal_name, input logic expected,
                                 input logic actual);
    $display("ERROR %s: %s expected %0b actual %0b at cycle %0d",
             test_name, signal_name, expected, actual, cycle_count);
    $display("TEST FAILED");
    $fatal(1, "Output mismatch");
  endtask

  task automatic report_failure(input string what);
    $display("Failure in %s: %s at cycle %0d", test_name, what, cycle_count);
    $display("TEST FAILED");
    $fatal(1, "Check failed");
  endtask

  // Outputs only move at rising edges, so the falling edge sees settled values
  buzzer_check: assert property (@(negedge clk) disable iff (!rst_n)
    buzzer === exp_buzzer)
    else report_mismatch("buzzer", exp_buzzer, buzzer);

  buzzer_n_check: assert property (@(negedge clk) disable iff (!rst_n)
    buzzer_n === exp_buzzer_n)
    else report_mismatch("buzzer_n", exp_buzzer_n, buzzer_n);

  busy_check: assert property (@(negedge clk) disable iff (!rst_n)
    busy === exp_busy)
    else report_mismatch("busy", exp_busy, busy);

  comp_inverse: assert property (@(negedge clk) disable iff (!rst_n)
    (exp_on && m_cfg.ctrl.comp_en) |-> (buzzer_n === !buzzer))
    else report_failure("buzzer_n is not the inverse of buzzer during a tone");

  comp_quiet: assert property (@(negedge clk) disable iff (!rst_n)
    !m_cfg.ctrl.comp_en |-> (buzzer_n === 1'b0))
    else report_failure("buzzer_n is driven while comp_en is clear");

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAILED");
      $fatal(1, "Timeout");
    end
  end

  // Returns at the edge that samples the write
  task automatic write_reg(input logic a, input logic [3:0] d);
    @(posedge clk);
    wr    <= 1'b1;
    addr  <= a;
    wdata <= d;
    @(posedge clk);
    wr <= 1'b0;
  endtask

  // Moves past edge W+1, where a new tone has just started low
  task automatic settle_after_write();
    @(negedge clk);
    @(negedge clk);
  endtask

  task automatic wait_toggles(input int n);
    int   seen;
    logic prev;
    seen = 0;
    prev = buzzer;
    while (seen < n) begin
      @(negedge clk);
      if (buzzer !== prev) begin
        seen++;
      end
      prev = buzzer;
    end
  endtask

  task automatic wait_idle();
    while (busy) begin
      @(negedge clk);
    end
  endtask

  task automatic start_tone(input logic [2:0] sel, input logic comp, input logic cont);
    ctrl_reg_t c;
    freq_reg_t f;
    c = '{pin_en: 1'b1, comp_en: comp, continuous: cont, reserved: 1'b0};
    f = '{enable: 1'b1, sel: sel};
    write_reg(ADDR_CTRL, 4'(c));
    write_reg(ADDR_FREQ, 4'(f));
    settle_after_write();
  endtask

  // Stop through enable, or through pin_en when by_ctrl is set
  task automatic stop_tone(input logic by_ctrl);
    freq_reg_t f;
    ctrl_reg_t c;
    f = '{enable: 1'b0, sel: m_cfg.freq.sel};
    c = m_cfg.ctrl;
    c.pin_en = 1'b0;
    if (by_ctrl) begin
      write_reg(ADDR_CTRL, 4'(c));
    end else begin
      write_reg(ADDR_FREQ, 4'(f));
    end
    settle_after_write();
    wait_idle();
  endtask

  initial begin
    logic [2:0] sel;
    logic       comp;
    freq_reg_t  f;
    seed        = 32'hc94a6480;
    test_name   = "reset";
    rst_n       = 1'b0;
    wr          = 1'b0;
    addr        = 1'b0;
    wdata       = 4'd0;

    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    repeat (3) @(negedge clk);  // Idle outputs after reset

    for (int s = 0; s < 8; s++) begin
      test_name = $sformatf("continuous sel %0d", s);
      start_tone(3'(s), (s % 2 == 0), 1'b1);  // comp_en on even selects
      wait_toggles(4);
      stop_tone(1'b0);
    end

    for (int i = 0; i < N_BURSTS; i++) begin
      sel  = 3'($random(seed));
      comp = 1'($random(seed));
      test_name = $sformatf("burst %0d sel %0d", i, sel);
      start_tone(sel, comp, 1'b0);
      wait_idle();
    end

    test_name = "stop by enable";
    start_tone(3'd3, 1'b1, 1'b1);
    wait_toggles(3);  // Buzzer high when the stop lands
    stop_tone(1'b0);

    test_name = "stop by pin_en";
    start_tone(3'd6, 1'b1, 1'b1);
    wait_toggles(1);
    stop_tone(1'b1);

    test_name = "frequency change";
    start_tone(3'd5, 1'b1, 1'b1);
    wait_toggles(3);
    f = '{enable: 1'b1, sel: 3'd1};
    write_reg(ADDR_FREQ, 4'(f));
    settle_after_write();
    wait_toggles(4);  // New phase from the rewrite
    stop_tone(1'b0);

    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/buzzer_top.sv ====
`default_nettype none

module buzzer_top
  import buzzer_pkg::*;
#(
  parameter int BURST_LEN = 8
) (
  input  logic       clk,      // 32.768 kHz system clock
  input  logic       rst_n,
  input  logic       wr,
  input  logic       addr,
  input  logic [3:0] wdata,
  output logic       buzzer,
  output logic       buzzer_n,
  output logic       busy
);

  buzz_cfg_t cfg;
  logic      restart;
  logic      run;
  logic      tick;

  // CPU-facing registers
  buzzer_regs u_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr      (wr),
    .addr    (addr),
    .wdata   (wdata),
    .cfg     (cfg),
    .restart (restart)
  );

  // Half-period timing from the frequency select
  buzzer_timer u_timer (
    .clk     (clk),
    .rst_n   (rst_n),
    .run     (run),
    .restart (restart),
    .sel     (cfg.freq.sel),
    .tick    (tick)
  );

  buzzer_fsm #(
    .BURST_LEN (BURST_LEN)
  ) u_fsm (
    .clk     (clk),
    .rst_n   (rst_n),
    .cfg     (cfg),
    .restart (restart),
    .tick    (tick),
    .run     (run),
    .busy    (busy)
  );

  // Pin drivers
  buzzer_wave u_wave (
    .clk      (clk),
    .rst_n    (rst_n),
    .cfg      (cfg),
    .run      (run),
    .restart  (restart),
    .tick     (tick),
    .buzzer   (buzzer),
    .buzzer_n (buzzer_n)
  );

endmodule

`default_nettype wire

// ==== hw/buzzer_wave.sv ====
`default_nettype none

module buzzer_wave
  import buzzer_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  buzz_cfg_t cfg,
  input  logic      run,
  input  logic      restart,
  input  logic      tick,
  output logic      buzzer,
  output logic      buzzer_n
);

  logic phase;    // Square wave before pin gating
  logic pins_on;

  // Every tone starts on the low half
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      phase <= 1'b0;
    end else if (restart || !run) begin
      phase <= 1'b0;
    end else if (tick) begin
      phase <= ~phase;
    end
  end

  // Config gating silences the pins as soon as a stop is written
  assign pins_on = run && cfg.freq.enable && cfg.ctrl.pin_en;

  assign buzzer   = pins_on && phase;
  assign buzzer_n = pins_on && cfg.ctrl.comp_en && !phase;  // Push-pull drive

endmodule

`default_nettype wire

// ==== hw/buzzer_fsm.sv ====
`default_nettype none

module buzzer_fsm
  import buzzer_pkg::*;
#(
  parameter int BURST_LEN = 8  // Half periods per burst
) (
  input  logic      clk,
  input  logic      rst_n,
  input  buzz_cfg_t cfg,
  input  logic      restart,
  input  logic      tick,
  output logic      run,
  output logic      busy
);

  localparam int CNT_W = $clog2(BURST_LEN + 1);

  buzz_state_t      state;
  buzz_state_t      state_nxt;
  logic [CNT_W-1:0] ticks;      // Half periods played in this burst
  logic [CNT_W-1:0] ticks_nxt;
  logic             tone_on;    // Written config asks for a tone
  logic             last_tick;

  assign tone_on   = cfg.freq.enable && cfg.ctrl.pin_en;
  assign last_tick = (ticks == CNT_W'(BURST_LEN - 1));

  always_comb begin
    state_nxt = state;
    ticks_nxt = ticks;

    if (restart) begin
      // Any write restarts from scratch, whatever the state
      ticks_nxt = '0;
      if (!tone_on) begin
        state_nxt = IDLE;
      end else if (cfg.ctrl.continuous) begin
        state_nxt = CONT;
      end else begin
        state_nxt = BURST;
      end
    end else begin
      case (state)
        BURST: begin
          if (tick) begin
            if (last_tick) begin
              state_nxt = DONE;  // Final toggle lands with busy falling
            end else begin
              ticks_nxt = ticks + CNT_W'(1);
            end
          end
        end
        CONT:    state_nxt = CONT;  // Only a write leaves continuous play
        DONE:    state_nxt = DONE;
        default: state_nxt = IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
      ticks <= '0;
    end else begin
      state <= state_nxt;
      ticks <= ticks_nxt;
    end
  end

  assign run  = (state == CONT) || (state == BURST);
  assign busy = (state == CONT) || (state == BURST);

endmodule

`default_nettype wire

// ==== hw/buzzer_timer.sv ====
`default_nettype none

module buzzer_timer
  import buzzer_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       run,      // Tone active, from the FSM
  input  logic       restart,  // Realign the count to a new tone
  input  logic [2:0] sel,
  output logic       tick      // One cycle per elapsed half period
);

  logic [HP_W-1:0] cnt;
  logic [HP_W-1:0] reload;

  // Count runs from reload down to zero, H clocks per half period
  assign reload = half_period(sel) - HP_W'(1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (restart) begin
      // The restart edge already counts as the first clock
      cnt <= reload - HP_W'(1);
    end else if (!run) begin
      cnt <= reload;  // Park at the top while silent
    end else if (cnt == '0) begin
      cnt <= reload;
    end else begin
      cnt <= cnt - HP_W'(1);
    end
  end

  // A stale zero from the previous tone must not leak out
  // during the restart cycle
  assign tick = run && !restart && (cnt == '0);

endmodule

`default_nettype wire

// ==== hw/buzzer_regs.sv ====
`default_nettype none

module buzzer_regs
  import buzzer_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       wr,       // Single-cycle write strobe
  input  logic       addr,
  input  logic [3:0] wdata,
  output buzz_cfg_t  cfg,
  output logic       restart   // One cycle after every write
);

  freq_reg_t freq_q;
  ctrl_reg_t ctrl_q;

  // Register load happens at the edge that samples wr
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      freq_q <= '0;
      ctrl_q <= '0;
    end else if (wr) begin
      if (addr == ADDR_FREQ) begin
        freq_q <= freq_reg_t'(wdata);
      end else if (addr == ADDR_CTRL) begin
        ctrl_q <= ctrl_reg_t'(wdata);
      end
    end
  end

  // Restart follows the write by one cycle so that the
  // new register contents are already visible downstream
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      restart <= 1'b0;
    end else begin
      restart <= wr;
    end
  end

  assign cfg = '{freq: freq_q, ctrl: ctrl_q};

endmodule

`default_nettype wire

// ==== common/buzzer_pkg.sv ====
`default_nettype none

package buzzer_pkg;

  // Width of a half-period count in clocks
  localparam int HP_W = 5;

  // Register addresses on the CPU write port
  localparam logic ADDR_FREQ = 1'b0;
  localparam logic ADDR_CTRL = 1'b1;

  // Frequency select register
  typedef struct packed {
    logic       enable;  // Tone generator on
    logic [2:0] sel;     // Index into the half-period table
  } freq_reg_t;

  // Output control register
  typedef struct packed {
    logic pin_en;      // Drive the buzzer pin
    logic comp_en;     // Drive buzzer_n as the complement
    logic continuous;  // 1 plays until stopped, 0 plays one burst
    logic reserved;
  } ctrl_reg_t;

  // Full configuration seen by the FSM and the pin drivers
  typedef struct packed {
    freq_reg_t freq;
    ctrl_reg_t ctrl;
  } buzz_cfg_t;

  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    CONT  = 2'd1,
    BURST = 2'd2,
    DONE  = 2'd3
  } buzz_state_t;

  // Half period in clocks for each frequency select
  // clk/16 at sel 0 down to clk/56 at sel 7
  function automatic logic [HP_W-1:0] half_period(input logic [2:0] sel);
    logic [HP_W-1:0] hp;
    case (sel)
      3'd0:    hp = 5'd8;
      3'd1:    hp = 5'd10;
      3'd2:    hp = 5'd12;
      3'd3:    hp = 5'd14;
      3'd4:    hp = 5'd16;
      3'd5:    hp = 5'd20;
      3'd6:    hp = 5'd24;
      default: hp = 5'd28;
    endcase
    return hp;
  endfunction

endpackage

`default_nettype wire
